//--- Makefile
# Verilator build and run for the UART testbench, from the project root

VERILATOR  ?= verilator
TOP        ?= uart_tb
LINT_TOP   ?= uart_top
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/uart_patterns.txt
# Columns: mode (R receive, F low stop bit, O overrun, T transmit),
# byte in hex, divisor in clock cycles per bit
R 55 16
R a3 8
R 0f 7
R c8 5
F 3c 16
F 81 9
O 12 16
O e7 6
T 55 16
T a3 8
T 96 7
T 01 4
T ff 13
R 7e 13
O 00 10
R 80 6

//--- sim/uart_tb.sv
/*
 * Self-checking testbench for the UART peripheral. Tests are read from
 * the pattern file, one per line, and each one programs the divisor,
 * then drives serial frames or a transmit and checks status, data and
 * the serial output. Run from the project root.
 */
`default_nettype none

module uart_tb import uart_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk;
    logic                     rst_n;
    logic                     rx_line;
    logic [REG_ADDR_SIZE-1:0] addr;
    logic                     wr_en;
    logic [BUS_DATA_SIZE-1:0] wr_data;
    logic                     rd_en;
    logic [BUS_DATA_SIZE-1:0] rd_data;
    logic                     tx_line;

    logic [7:0] test_mode [$];
    logic [7:0] test_byte [$];
    int         test_div [$];
    int         error_count;
    int         tests_failed;
    int         watchdog_ns;

    uart_top uart_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_i      (rx_line),
        .addr_i    (addr),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_data_o (rd_data),
        .tx_o      (tx_line)
    );

    always #2 clk = ~clk;

    // One status flag at its bit position
    function automatic logic [BUS_DATA_SIZE-1:0] flag(input int pos);
        return BUS_DATA_SIZE'(1) << pos;
    endfunction

    task automatic check(input logic [BUS_DATA_SIZE-1:0] got,
                         input logic [BUS_DATA_SIZE-1:0] expected, input string what);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s, got 0x%h, expected 0x%h", $time, what, got, expected);
            error_count++;
        end
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input logic [REG_ADDR_SIZE-1:0] a,
                             input logic [BUS_DATA_SIZE-1:0] d);
        addr    = a;
        wr_data = d;
        wr_en   = 1'b1;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    task automatic bus_read(input logic [REG_ADDR_SIZE-1:0] a,
                            output logic [BUS_DATA_SIZE-1:0] d);
        addr  = a;
        rd_en = 1'b1;
        @(posedge clk);
        #1;
        rd_en = 1'b0;
        d     = rd_data;
    endtask

    // Reads status until one flag reaches the wanted level
    task automatic poll_status(input int pos, input logic level, input int limit);
        logic [BUS_DATA_SIZE-1:0] st;
        int reads;
        reads = 1;
        bus_read(REG_STATUS, st);
        while (st[pos] !== level && reads < limit) begin
            bus_read(REG_STATUS, st);
            reads++;
        end
        if (st[pos] !== level) begin
            $display("Status bit %0d did not become %0b within %0d reads, at %0d ns",
                     pos, level, limit, $time);
            error_count++;
        end
    endtask

    // Random idle gap, then start bit, data LSB first and the given stop bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit, input int div);
        logic [9:0] frame;
        int gap;
        frame = {stop_bit, data, 1'b0};
        gap   = $urandom % 21;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < 10; k++) begin
            rx_line = frame[k];
            repeat (div) @(posedge clk);
            #1;
        end
        rx_line = 1'b1;
    endtask

    task automatic run_receive(input logic [7:0] data, input int div);
        logic [BUS_DATA_SIZE-1:0] v;
        send_frame(data, 1'b1, div);
        poll_status(ST_RX_FULL, 1'b1, 30 * div);
        bus_read(REG_STATUS, v);
        check(v, flag(ST_RX_FULL), "status after a good frame");
        bus_read(REG_DATA, v);
        check(v, BUS_DATA_SIZE'(data), "received byte");
        bus_read(REG_STATUS, v);
        check(v, '0, "status after the DATA read");
    endtask

    task automatic run_frame_error(input logic [7:0] data, input int div);
        logic [BUS_DATA_SIZE-1:0] v;
        send_frame(data, 1'b0, div);
        poll_status(ST_FRAME_ERR, 1'b1, 30 * div);
        bus_read(REG_STATUS, v);
        check(v, flag(ST_FRAME_ERR), "status after a low stop bit");
        bus_write(REG_STATUS, flag(ST_FRAME_ERR));
        bus_read(REG_STATUS, v);
        check(v, '0, "status after clearing frame_err");
    endtask

    // First frame carries the inverted byte so the two can be told apart
    task automatic run_overrun(input logic [7:0] data, input int div);
        logic [BUS_DATA_SIZE-1:0] v;
        send_frame(~data, 1'b1, div);
        poll_status(ST_RX_FULL, 1'b1, 30 * div);
        send_frame(data, 1'b1, div);
        poll_status(ST_OVERRUN, 1'b1, 30 * div);
        bus_read(REG_STATUS, v);
        check(v, flag(ST_RX_FULL) | flag(ST_OVERRUN), "status after two unread frames");
        bus_read(REG_DATA, v);
        check(v, BUS_DATA_SIZE'(data), "DATA holds the second byte");
        bus_write(REG_STATUS, flag(ST_OVERRUN));
        bus_read(REG_STATUS, v);
        check(v, '0, "status after the read and the overrun clear");
    endtask

    task automatic run_transmit(input logic [7:0] data, input int div);
        logic [BUS_DATA_SIZE-1:0] v;
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        bus_write(REG_DATA, BUS_DATA_SIZE'(data));
        check(BUS_DATA_SIZE'(tx_line), '0, "tx_o low in the cycle after the write");
        bus_read(REG_STATUS, v);
        check(v, flag(ST_TX_BUSY), "status right after the DATA write");
        // The start bit began at the write edge and the read used one cycle of it
        repeat (div / 2 - 1) @(posedge clk);
        #1;
        for (int k = 0; k < 10; k++) begin
            if (k > 0) begin
                repeat (div) @(posedge clk);
                #1;
            end
            check(BUS_DATA_SIZE'(tx_line), BUS_DATA_SIZE'(frame[k]),
                  $sformatf("tx_o in the middle of bit %0d", k));
        end
        poll_status(ST_TX_BUSY, 1'b0, 4 * div);
        bus_read(REG_STATUS, v);
        check(v, '0, "status after the frame is sent");
    endtask

    // Each line holds a mode letter, a byte in hex and a decimal divisor
    // Lines starting with # are skipped
    task automatic load_patterns();
        int fd;
        int ch;
        int d;
        int limit_ns;
        logic [7:0] c;
        logic [7:0] b;
        limit_ns = 2000;
        fd = $fopen("sim/uart_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/uart_patterns.txt from the current directory");
            error_count++;
            watchdog_ns = limit_ns;
            return;
        end
        ch = $fgetc(fd);
        while (ch != -1) begin
            c = ch[7:0];
            if (c == "#") begin
                while (ch != -1 && ch[7:0] != 8'h0a) begin
                    ch = $fgetc(fd);
                end
            end else if (c == "R" || c == "F" || c == "O" || c == "T") begin
                if ($fscanf(fd, "%h %d", b, d) == 2 && d > 1) begin
                    test_mode.push_back(c);
                    test_byte.push_back(b);
                    test_div.push_back(d);
                    limit_ns += 30 * d * 4 + 200;
                end else begin
                    $display("Pattern line with mode %c has a bad byte or divisor", c);
                    error_count++;
                end
            end
            ch = $fgetc(fd);
        end
        $fclose(fd);
        watchdog_ns = limit_ns;
        if (test_mode.size() == 0) begin
            $display("The pattern file holds no tests");
            error_count++;
        end
    endtask

    task automatic report_test(input int idx, input string what, input int errors_before);
        if (error_count == errors_before) begin
            $display("test %0d %s: ok", idx, what);
        end else begin
            $display("test %0d %s: %0d errors", idx, what, error_count - errors_before);
            tests_failed++;
        end
    endtask

    initial begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        logic [BUS_DATA_SIZE-1:0] v;
        int errors_before;
        void'($urandom(15253));
        clk          = 1'b0;
        rst_n        = 1'b0;
        rx_line      = 1'b1;
        addr         = '0;
        wr_en        = 1'b0;
        wr_data      = '0;
        rd_en        = 1'b0;
        error_count  = 0;
        tests_failed = 0;
        load_patterns();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        errors_before = error_count;
        check(BUS_DATA_SIZE'(tx_line), BUS_DATA_SIZE'(1), "tx_o level after reset");
        check(rd_data, '0, "read data after reset");
        bus_read(REG_STATUS, v);
        check(v, '0, "status after reset");
        bus_read(REG_BAUD, v);
        check(v, BUS_DATA_SIZE'(16), "divisor after reset");
        report_test(0, "reset values", errors_before);

        for (int i = 0; i < test_mode.size(); i++) begin
            errors_before = error_count;
            bus_write(REG_BAUD, BUS_DATA_SIZE'(test_div[i]));
            case (test_mode[i])
                "R": run_receive(test_byte[i], test_div[i]);
                "F": run_frame_error(test_byte[i], test_div[i]);
                "O": run_overrun(test_byte[i], test_div[i]);
                // Loading keeps only the four modes, so this is T
                default: run_transmit(test_byte[i], test_div[i]);
            endcase
            report_test(i + 1, $sformatf("mode %c byte 0x%h divisor %0d",
                        test_mode[i], test_byte[i], test_div[i]), errors_before);
        end

        $display("%0d tests, %0d failed, %0d failing checks",
                 test_mode.size() + 1, tests_failed, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
/*
 * Sizes, register map, status bit positions and FSM state codes shared
 * by the UART peripheral. Modules take these in with a wildcard import.
 */
`default_nettype none

package uart_pkg;

    // Frame and divisor sizes
    localparam int UART_DATA_SIZE     = 8;
    localparam int UART_BIT_CNT_SIZE  = 3;
    localparam int UART_BAUD_DIV_SIZE = 16;
    localparam logic [UART_BAUD_DIV_SIZE-1:0] UART_BAUD_DIV_RESET = 16'd16;

    // Core side bus
    localparam int BUS_DATA_SIZE = 16;
    localparam int REG_ADDR_SIZE = 2;

    // Register map
    localparam logic [REG_ADDR_SIZE-1:0] REG_DATA   = 2'd0;
    localparam logic [REG_ADDR_SIZE-1:0] REG_STATUS = 2'd1;
    localparam logic [REG_ADDR_SIZE-1:0] REG_BAUD   = 2'd2;

    // Bit positions in the status word
    localparam int ST_RX_FULL   = 0;
    localparam int ST_FRAME_ERR = 1;
    localparam int ST_OVERRUN   = 2;
    localparam int ST_TX_BUSY   = 3;

    // FSM state codes
    localparam int STATE_SIZE = 2;

    localparam logic [STATE_SIZE-1:0] RX_IDLE  = 2'd0;
    localparam logic [STATE_SIZE-1:0] RX_START = 2'd1;
    localparam logic [STATE_SIZE-1:0] RX_DATA  = 2'd2;
    localparam logic [STATE_SIZE-1:0] RX_STOP  = 2'd3;

    localparam logic [STATE_SIZE-1:0] TX_IDLE  = 2'd0;
    localparam logic [STATE_SIZE-1:0] TX_START = 2'd1;
    localparam logic [STATE_SIZE-1:0] TX_DATA  = 2'd2;
    localparam logic [STATE_SIZE-1:0] TX_STOP  = 2'd3;

endpackage

`default_nettype wire

//--- source/uart_regs.sv
/*
 * Register block on the core side. Holds the divisor, the last received
 * byte and sticky status flags, and turns a DATA write into a transmit
 * strobe. Reads are registered and return one cycle after rd_en_i.
 */
`default_nettype none

module uart_regs import uart_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          wr_en_i,
    input  wire logic                          rd_en_i,
    input  wire logic [REG_ADDR_SIZE-1:0]      addr_i,
    input  wire logic [BUS_DATA_SIZE-1:0]      wr_data_i,
    output logic      [BUS_DATA_SIZE-1:0]      rd_data_o,
    input  wire logic [UART_DATA_SIZE-1:0]     rx_data_i,
    input  wire logic                          rx_valid_i,
    input  wire logic                          rx_frame_err_i,
    input  wire logic                          tx_busy_i,
    output logic      [UART_BAUD_DIV_SIZE-1:0] baud_div_o,
    output logic      [UART_DATA_SIZE-1:0]     tx_data_o,
    output logic                               tx_start_o
);

    logic [UART_BAUD_DIV_SIZE-1:0] baud_div_q;
    logic [UART_DATA_SIZE-1:0]     rx_byte_q;
    logic                          rx_full_q, frame_err_q, overrun_q;
    logic [BUS_DATA_SIZE-1:0]      rd_data_q;
    logic [BUS_DATA_SIZE-1:0]      status;
    logic                          rd_data, wr_status, wr_baud;

    assign rd_data   = rd_en_i && (addr_i == REG_DATA);
    assign wr_status = wr_en_i && (addr_i == REG_STATUS);
    assign wr_baud   = wr_en_i && (addr_i == REG_BAUD);

    always_comb begin
        status               = '0;
        status[ST_RX_FULL]   = rx_full_q;
        status[ST_FRAME_ERR] = frame_err_q;
        status[ST_OVERRUN]   = overrun_q;
        status[ST_TX_BUSY]   = tx_busy_i;
    end

    // A new event this cycle wins over a clear of the same flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_div_q  <= UART_BAUD_DIV_RESET;
            rx_byte_q   <= '0;
            rx_full_q   <= 1'b0;
            frame_err_q <= 1'b0;
            overrun_q   <= 1'b0;
        end else begin
            if (wr_baud) begin
                baud_div_q <= wr_data_i[UART_BAUD_DIV_SIZE-1:0];
            end

            if (rx_valid_i) begin
                rx_byte_q <= rx_data_i;
                rx_full_q <= 1'b1;
            end else if (rd_data || (wr_status && wr_data_i[ST_RX_FULL])) begin
                rx_full_q <= 1'b0;
            end

            if (rx_valid_i && rx_full_q && !rd_data) begin
                overrun_q <= 1'b1;
            end else if (wr_status && wr_data_i[ST_OVERRUN]) begin
                overrun_q <= 1'b0;
            end

            if (rx_frame_err_i) begin
                frame_err_q <= 1'b1;
            end else if (wr_status && wr_data_i[ST_FRAME_ERR]) begin
                frame_err_q <= 1'b0;
            end
        end
    end

    // Read data holds until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            case (addr_i)
                REG_DATA:   rd_data_q <= BUS_DATA_SIZE'(rx_byte_q);
                REG_STATUS: rd_data_q <= status;
                REG_BAUD:   rd_data_q <= BUS_DATA_SIZE'(baud_div_q);
                default:    rd_data_q <= '0;
            endcase
        end
    end

    // A DATA write while the transmitter is busy is dropped
    assign tx_start_o = wr_en_i && (addr_i == REG_DATA) && !tx_busy_i;
    assign tx_data_o  = wr_data_i[UART_DATA_SIZE-1:0];
    assign baud_div_o = baud_div_q;
    assign rd_data_o  = rd_data_q;

    // The transmitter must pick up every accepted strobe
    a_start_makes_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start_o |=> tx_busy_i);

endmodule

`default_nettype wire

//--- source/uart_rx.sv
/*
 * UART receiver, 8N1, LSB first. The line is synchronized, the start bit
 * is checked at its midpoint, and each later bit is sampled one divisor
 * period after the previous one. A good frame gives a valid_o pulse, a
 * low stop bit gives a frame_err_o pulse instead.
 */
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          rx_i,
    input  wire logic [UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    output logic      [UART_DATA_SIZE-1:0]     rx_data_o,
    output logic                               valid_o,
    output logic                               frame_err_o
);

    logic rx_meta, rx_sync, rx_prev;
    logic rx_fall;

    logic [STATE_SIZE-1:0]         state_q, state_d;
    logic [UART_BAUD_DIV_SIZE-1:0] sample_cnt_q, sample_cnt_d;
    logic [UART_BAUD_DIV_SIZE-1:0] mid_cnt_q, mid_cnt_d;
    logic [UART_BIT_CNT_SIZE-1:0]  bit_cnt_q, bit_cnt_d;
    logic [UART_DATA_SIZE-1:0]     shifter_q, shifter_d;
    logic                          valid_q, valid_d;
    logic                          frame_err_q, frame_err_d;

    // Two-flop synchronizer, plus one more stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    // Only a falling edge arms the receiver, so a held low line is not a frame
    assign rx_fall = rx_prev && !rx_sync;

    always_comb begin
        state_d      = state_q;
        sample_cnt_d = sample_cnt_q;
        mid_cnt_d    = mid_cnt_q;
        bit_cnt_d    = bit_cnt_q;
        shifter_d    = shifter_q;
        valid_d      = 1'b0;
        frame_err_d  = 1'b0;

        case (state_q)
            RX_IDLE: begin
                if (rx_fall) begin
                    mid_cnt_d = baud_div_i >> 1;
                    state_d   = RX_START;
                end
            end
            RX_START: begin
                if (mid_cnt_q == '0) begin
                    if (rx_sync) begin
                        // Line went high again, treat as a glitch
                        state_d = RX_IDLE;
                    end else begin
                        sample_cnt_d = baud_div_i - 1'b1;
                        bit_cnt_d    = '0;
                        state_d      = RX_DATA;
                    end
                end else begin
                    mid_cnt_d = mid_cnt_q - 1'b1;
                end
            end
            RX_DATA: begin
                if (sample_cnt_q == '0) begin
                    shifter_d    = {rx_sync, shifter_q[UART_DATA_SIZE-1:1]};
                    sample_cnt_d = baud_div_i - 1'b1;
                    bit_cnt_d    = bit_cnt_q + 1'b1;
                    if (bit_cnt_q == UART_BIT_CNT_SIZE'(UART_DATA_SIZE - 1)) begin
                        state_d = RX_STOP;
                    end
                end else begin
                    sample_cnt_d = sample_cnt_q - 1'b1;
                end
            end
            RX_STOP: begin
                if (sample_cnt_q == '0) begin
                    valid_d     = rx_sync;
                    frame_err_d = !rx_sync;
                    state_d     = RX_IDLE;
                end else begin
                    sample_cnt_d = sample_cnt_q - 1'b1;
                end
            end
            default: state_d = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= RX_IDLE;
            sample_cnt_q <= '0;
            mid_cnt_q    <= '0;
            bit_cnt_q    <= '0;
            valid_q      <= 1'b0;
            frame_err_q  <= 1'b0;
        end else begin
            state_q      <= state_d;
            sample_cnt_q <= sample_cnt_d;
            mid_cnt_q    <= mid_cnt_d;
            bit_cnt_q    <= bit_cnt_d;
            valid_q      <= valid_d;
            frame_err_q  <= frame_err_d;
        end
    end

    always_ff @(posedge clk) begin
        shifter_q <= shifter_d;
    end

    assign rx_data_o   = shifter_q;
    assign valid_o     = valid_q;
    assign frame_err_o = frame_err_q;

    // A frame ends either good or bad, never both
    a_rx_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(valid_o && frame_err_o));

endmodule

`default_nettype wire

//--- source/uart_top.sv
/*
 * UART peripheral top level. Connects the register block on the core
 * side to the serial receiver and transmitter.
 */
`default_nettype none

module uart_top import uart_pkg::*; (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     rx_i,
    input  wire logic [REG_ADDR_SIZE-1:0] addr_i,
    input  wire logic                     wr_en_i,
    input  wire logic [BUS_DATA_SIZE-1:0] wr_data_i,
    input  wire logic                     rd_en_i,
    output logic      [BUS_DATA_SIZE-1:0] rd_data_o,
    output logic                          tx_o
);

    logic [UART_BAUD_DIV_SIZE-1:0] baud_div;
    logic [UART_DATA_SIZE-1:0]     tx_data;
    logic                          tx_start;
    logic                          tx_busy;
    logic [UART_DATA_SIZE-1:0]     rx_data;
    logic                          rx_valid;
    logic                          rx_frame_err;

    uart_regs uart_regs_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_en_i        (wr_en_i),
        .rd_en_i        (rd_en_i),
        .addr_i         (addr_i),
        .wr_data_i      (wr_data_i),
        .rd_data_o      (rd_data_o),
        .rx_data_i      (rx_data),
        .rx_valid_i     (rx_valid),
        .rx_frame_err_i (rx_frame_err),
        .tx_busy_i      (tx_busy),
        .baud_div_o     (baud_div),
        .tx_data_o      (tx_data),
        .tx_start_o     (tx_start)
    );

    uart_rx uart_rx_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_i        (rx_i),
        .baud_div_i  (baud_div),
        .rx_data_o   (rx_data),
        .valid_o     (rx_valid),
        .frame_err_o (rx_frame_err)
    );

    uart_tx uart_tx_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (tx_start),
        .data_i     (tx_data),
        .baud_div_i (baud_div),
        .tx_o       (tx_o),
        .busy_o     (tx_busy)
    );

endmodule

`default_nettype wire

//--- source/uart_tx.sv
/*
 * UART transmitter, 8N1, LSB first. A start_i pulse loads the byte and
 * sends start, data and stop bits, each held for baud_div_i cycles.
 * busy_o stays high from the cycle after start_i until the stop bit ends.
 */
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          start_i,
    input  wire logic [UART_DATA_SIZE-1:0]     data_i,
    input  wire logic [UART_BAUD_DIV_SIZE-1:0] baud_div_i,
    output logic                               tx_o,
    output logic                               busy_o
);

    logic [STATE_SIZE-1:0]         state_q;
    logic [UART_BAUD_DIV_SIZE-1:0] period_cnt_q;
    logic [UART_BIT_CNT_SIZE-1:0]  bit_cnt_q;
    logic [UART_DATA_SIZE-1:0]     shifter_q;
    logic                          tx_q;
    logic                          period_done;

    assign period_done = (period_cnt_q == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= TX_IDLE;
            period_cnt_q <= '0;
            bit_cnt_q    <= '0;
            tx_q         <= 1'b1;
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (start_i) begin
                        // Start bit goes out on the next cycle
                        tx_q         <= 1'b0;
                        period_cnt_q <= baud_div_i - 1'b1;
                        state_q      <= TX_START;
                    end
                end
                TX_START: begin
                    if (period_done) begin
                        tx_q         <= shifter_q[0];
                        bit_cnt_q    <= '0;
                        period_cnt_q <= baud_div_i - 1'b1;
                        state_q      <= TX_DATA;
                    end else begin
                        period_cnt_q <= period_cnt_q - 1'b1;
                    end
                end
                TX_DATA: begin
                    if (period_done) begin
                        period_cnt_q <= baud_div_i - 1'b1;
                        if (bit_cnt_q == UART_BIT_CNT_SIZE'(UART_DATA_SIZE - 1)) begin
                            tx_q    <= 1'b1;
                            state_q <= TX_STOP;
                        end else begin
                            tx_q      <= shifter_q[1];
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                        end
                    end else begin
                        period_cnt_q <= period_cnt_q - 1'b1;
                    end
                end
                TX_STOP: begin
                    if (period_done) begin
                        state_q <= TX_IDLE;
                    end else begin
                        period_cnt_q <= period_cnt_q - 1'b1;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Bit 0 of the payload shifter is the bit on the line or the next one
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && start_i) begin
            shifter_q <= data_i;
        end else if (state_q == TX_DATA && period_done) begin
            shifter_q <= shifter_q >> 1;
        end
    end

    assign tx_o   = tx_q;
    assign busy_o = (state_q != TX_IDLE);

    // Line idles high between frames
    a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o |-> tx_o);

endmodule

`default_nettype wire

//--- verilog.f
source/uart_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_regs.sv
source/uart_top.sv
sim/uart_tb.sv
